// File: verilog/cipher_pkg.sv
package cipher_pkg;
	localparam int BLOCK_W = 128;
	localparam int KEY_W = 128;
	localparam int HALF_W = 64;

	typedef logic [BLOCK_W-1:0] block_t;
	typedef logic [KEY_W-1:0] key_t;
	typedef logic [HALF_W-1:0] half_t;
	typedef logic [7:0] round_t;

	function automatic half_t rotl(half_t x, logic [5:0] s);
		return (x << s) | (x >> (7'd64 - s));
	endfunction

	// Even rounds use the low key half, odd rounds the high half
	function automatic half_t round_key(key_t key, round_t idx);
		half_t k;
		k = idx[0] ? key[KEY_W-1:HALF_W] : key[HALF_W-1:0];
		k = rotl(k, {idx[2:0], 3'b000});
		return k ^ half_t'(idx);
	endfunction

	function automatic half_t round_f(half_t h, half_t k);
		return (rotl(h, 6'd5) + k) ^ rotl(h, 6'd61);
	endfunction
endpackage

// File: verilog/ctrl_pkg.sv
package ctrl_pkg;
	typedef enum logic [1:0] {
		mode_ecb = 2'd0,
		mode_cbc = 2'd1,
		mode_ctr = 2'd2
	} mode_e;

	// Held stable by the sender for a whole stream
	typedef struct packed {
		mode_e mode;
		logic  decrypt;
	} cmd_t;

	typedef enum logic [2:0] {
		st_key   = 3'd0,
		st_iv    = 3'd1,
		st_block = 3'd2,
		st_wait  = 3'd3,
		st_store = 3'd4
	} ctrl_state_e;
endpackage

// File: verilog/block_fifo.sv
module block_fifo #(
	parameter int DEPTH = 8
) (
	input  logic              clk,
	input  logic              reset,
	input  cipher_pkg::block_t wr_data,
	input  logic              wr_valid,
	output logic              wr_ready,
	output cipher_pkg::block_t rd_data,
	output logic              rd_valid,
	input  logic              rd_ready,
	output logic              empty
);
	import cipher_pkg::*;

	localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
	localparam int CNT_W = $clog2(DEPTH + 1);

	block_t           mem [DEPTH];
	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic [CNT_W-1:0] count;
	logic [CNT_W-1:0] count_next;
	logic             wr_en;
	logic             rd_en;

	function automatic logic [PTR_W-1:0] bump(logic [PTR_W-1:0] ptr);
		return (ptr == PTR_W'(DEPTH - 1)) ? '0 : ptr + 1'b1;
	endfunction

	assign wr_en = wr_valid && wr_ready;
	assign rd_en = rd_valid && rd_ready;
	assign rd_valid = (count != '0);
	assign empty = (count == '0);
	assign rd_data = mem[rd_ptr];

	always_comb begin
		count_next = count;
		if (wr_en && !rd_en) begin
			count_next = count + 1'b1;
		end else if (rd_en && !wr_en) begin
			count_next = count - 1'b1;
		end
	end

	// Ready tracks the count, so it is low whenever the buffer is full
	always_ff @(posedge clk) begin
		if (reset) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
			wr_ready <= 1'b0;
		end else begin
			if (wr_en) begin
				wr_ptr <= bump(wr_ptr);
			end
			if (rd_en) begin
				rd_ptr <= bump(rd_ptr);
			end
			count <= count_next;
			wr_ready <= (count_next != CNT_W'(DEPTH));
		end
	end

	always_ff @(posedge clk) begin
		if (wr_en) begin
			mem[wr_ptr] <= wr_data;
		end
	end
endmodule

// File: verilog/feistel_core.sv
module feistel_core #(
	parameter int ROUNDS = 8
) (
	input  logic               clk,
	input  logic               reset,
	input  logic               start,
	input  logic               inverse,
	input  cipher_pkg::key_t   key,
	input  cipher_pkg::block_t din,
	output cipher_pkg::block_t result,
	output logic               done
);
	import cipher_pkg::*;

	localparam round_t LAST_IDX = round_t'(ROUNDS - 1);

	half_t  l_q;
	half_t  r_q;
	half_t  cur_l;
	half_t  cur_r;
	half_t  f_out;
	round_t idx_q;
	round_t cur_idx;
	logic   inv_q;
	logic   cur_inv;
	logic   busy;
	logic   last;

	// First round runs on the start cycle straight from din
	always_comb begin
		if (start) begin
			cur_l = din[BLOCK_W-1:HALF_W];
			cur_r = din[HALF_W-1:0];
			cur_inv = inverse;
			cur_idx = inverse ? LAST_IDX : '0;
		end else begin
			cur_l = l_q;
			cur_r = r_q;
			cur_inv = inv_q;
			cur_idx = idx_q;
		end
		f_out = round_f(cur_r, round_key(key, cur_idx));
		last = cur_inv ? (cur_idx == '0) : (cur_idx == LAST_IDX);
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			busy <= 1'b0;
			done <= 1'b0;
			inv_q <= 1'b0;
			idx_q <= '0;
		end else begin
			done <= 1'b0;
			if (start || busy) begin
				inv_q <= cur_inv;
				idx_q <= cur_inv ? cur_idx - 1'b1 : cur_idx + 1'b1;
				busy <= !last;
				done <= last;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (start || busy) begin
			l_q <= cur_r;
			r_q <= cur_l ^ f_out;
		end
	end

	// Halves swapped on the way out
	assign result = {r_q, l_q};
endmodule

// File: verilog/mode_chain.sv
module mode_chain (
	input  ctrl_pkg::mode_e    mode,
	input  logic               decrypt,
	input  cipher_pkg::block_t data,
	input  cipher_pkg::block_t iv,
	input  cipher_pkg::block_t core_out,
	output cipher_pkg::block_t core_in,
	output cipher_pkg::block_t out_blk,
	output cipher_pkg::block_t iv_next,
	output logic               core_inverse
);
	import ctrl_pkg::*;

	always_comb begin
		core_in = data;
		out_blk = core_out;
		iv_next = iv;
		core_inverse = decrypt;
		case (mode)
			mode_cbc: begin
				if (decrypt) begin
					out_blk = core_out ^ iv;
					iv_next = data;
					core_inverse = 1'b1;
				end else begin
					core_in = data ^ iv;
					iv_next = core_out;
					core_inverse = 1'b0;
				end
			end
			mode_ctr: begin
				// Counter goes through the core and data only meets the keystream
				core_in = iv;
				out_blk = core_out ^ data;
				iv_next = iv + 1'b1;
				core_inverse = 1'b0;
			end
			default: begin
				core_in = data;
				out_blk = core_out;
			end
		endcase
	end
endmodule

// File: verilog/cipher_controller.sv
module cipher_controller #(
	parameter int ROUNDS = 8
) (
	input  logic               clk,
	input  logic               reset,
	input  ctrl_pkg::cmd_t     cmd,
	input  logic               stream_end,
	input  cipher_pkg::block_t in_data,
	input  logic               in_valid,
	input  logic               in_empty,
	output logic               in_ready,
	output cipher_pkg::block_t out_data,
	output logic               out_valid,
	input  logic               out_ready,
	output logic               processing_done
);
	import cipher_pkg::*;
	import ctrl_pkg::*;

	ctrl_state_e state;

	key_t   key_q;
	block_t iv_q;
	block_t data_q;

	logic   start;
	logic   core_done;
	logic   core_inverse;
	block_t core_in;
	block_t core_out;
	block_t out_blk;
	block_t iv_next;

	logic   need_iv;
	logic   in_take;

	assign need_iv = (cmd.mode == mode_cbc) || (cmd.mode == mode_ctr);
	assign in_ready = (state == st_key) || (state == st_iv) || (state == st_block);
	assign in_take = in_valid && in_ready;

	mode_chain chain_i (
		.mode(cmd.mode),
		.decrypt(cmd.decrypt),
		.data(data_q),
		.iv(iv_q),
		.core_out(core_out),
		.core_in(core_in),
		.out_blk(out_blk),
		.iv_next(iv_next),
		.core_inverse(core_inverse)
	);

	feistel_core #(
		.ROUNDS(ROUNDS)
	) core_i (
		.clk(clk),
		.reset(reset),
		.start(start),
		.inverse(core_inverse),
		.key(key_q),
		.din(core_in),
		.result(core_out),
		.done(core_done)
	);

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= st_key;
			start <= 1'b0;
			out_valid <= 1'b0;
			processing_done <= 1'b0;
		end else begin
			start <= 1'b0;
			processing_done <= 1'b0;
			case (state)
				st_key: begin
					if (in_take) begin
						state <= need_iv ? st_iv : st_block;
					end
				end
				st_iv: begin
					if (in_take) begin
						state <= st_block;
					end
				end
				st_block: begin
					// Sender is finished and nothing is left queued
					if (stream_end && in_empty) begin
						processing_done <= 1'b1;
						state <= st_key;
					end else if (in_take) begin
						start <= 1'b1;
						state <= st_wait;
					end
				end
				st_wait: begin
					if (core_done) begin
						out_valid <= 1'b1;
						state <= st_store;
					end
				end
				st_store: begin
					if (out_ready) begin
						out_valid <= 1'b0;
						state <= st_block;
					end
				end
				default: begin
					state <= st_key;
				end
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (in_take) begin
			case (state)
				st_key: key_q <= in_data;
				st_iv: iv_q <= in_data;
				st_block: data_q <= in_data;
				default: begin
				end
			endcase
		end
		// IV moves on together with the stored result
		if (state == st_wait && core_done) begin
			out_data <= out_blk;
			iv_q <= iv_next;
		end
	end
endmodule

// File: verilog/cipher_top.sv
module cipher_top #(
	parameter int ROUNDS = 8,
	parameter int DEPTH  = 8
) (
	input  logic               clk,
	input  logic               reset,
	input  ctrl_pkg::cmd_t     cmd,
	input  logic               stream_end,
	input  cipher_pkg::block_t s_data,
	input  logic               s_valid,
	output logic               s_ready,
	output cipher_pkg::block_t m_data,
	output logic               m_valid,
	input  logic               m_ready,
	output logic               processing_done
);
	import cipher_pkg::*;

	block_t in_data;
	logic   in_valid;
	logic   in_empty;
	logic   in_ready;
	block_t out_data;
	logic   out_valid;
	logic   out_ready;

	block_fifo #(
		.DEPTH(DEPTH)
	) in_fifo_i (
		.clk(clk),
		.reset(reset),
		.wr_data(s_data),
		.wr_valid(s_valid),
		.wr_ready(s_ready),
		.rd_data(in_data),
		.rd_valid(in_valid),
		.rd_ready(in_ready),
		.empty(in_empty)
	);

	cipher_controller #(
		.ROUNDS(ROUNDS)
	) ctrl_i (
		.clk(clk),
		.reset(reset),
		.cmd(cmd),
		.stream_end(stream_end),
		.in_data(in_data),
		.in_valid(in_valid),
		.in_empty(in_empty),
		.in_ready(in_ready),
		.out_data(out_data),
		.out_valid(out_valid),
		.out_ready(out_ready),
		.processing_done(processing_done)
	);

	// Output side only needs the stream handshake
	block_fifo #(
		.DEPTH(DEPTH)
	) out_fifo_i (
		.clk(clk),
		.reset(reset),
		.wr_data(out_data),
		.wr_valid(out_valid),
		.wr_ready(out_ready),
		.rd_data(m_data),
		.rd_valid(m_valid),
		.rd_ready(m_ready),
		.empty()
	);
endmodule

// File: dv/cipher_assert.sv
module cipher_assert #(
	parameter int ROUNDS = 8
) (
	input logic               clk,
	input logic               reset,
	input cipher_pkg::block_t s_data,
	input logic               s_valid,
	input logic               s_ready,
	input cipher_pkg::block_t m_data,
	input logic               m_valid,
	input logic               m_ready,
	input logic               stream_end,
	input logic               processing_done,
	input logic               start,
	input logic               core_done
);
	timeunit 1ns;
	timeprecision 1ps;

	int fail_count;

	initial fail_count = 0;

	s_hold: assert property (@(posedge clk) disable iff (reset)
		s_valid && !s_ready |=> s_valid && $stable(s_data))
		else begin
			$error("input beat changed before it was accepted");
			fail_count++;
		end

	m_hold: assert property (@(posedge clk) disable iff (reset)
		m_valid && !m_ready |=> m_valid && $stable(m_data))
		else begin
			$error("output beat changed before it was taken");
			fail_count++;
		end

	// Core latency is fixed at ROUNDS cycles
	core_latency: assert property (@(posedge clk) disable iff (reset)
		core_done == $past(start, ROUNDS))
		else begin
			$error("core done not exactly ROUNDS cycles after start");
			fail_count++;
		end

	done_end: assert property (@(posedge clk) disable iff (reset)
		processing_done |-> stream_end)
		else begin
			$error("processing_done without stream_end");
			fail_count++;
		end

	done_pulse: assert property (@(posedge clk) disable iff (reset)
		processing_done |=> !processing_done)
		else begin
			$error("processing_done longer than one cycle");
			fail_count++;
		end

	reset_idle: assert property (@(posedge clk)
		reset |=> !m_valid && !s_ready && !processing_done)
		else begin
			$error("outputs not idle after reset");
			fail_count++;
		end
endmodule

bind cipher_top cipher_assert #(
	.ROUNDS(ROUNDS)
) assert_i (
	.clk(clk),
	.reset(reset),
	.s_data(s_data),
	.s_valid(s_valid),
	.s_ready(s_ready),
	.m_data(m_data),
	.m_valid(m_valid),
	.m_ready(m_ready),
	.stream_end(stream_end),
	.processing_done(processing_done),
	.start(ctrl_i.start),
	.core_done(ctrl_i.core_done)
);

// File: dv/cipher_tb.sv
module cipher_tb;
	timeunit 1ns;
	timeprecision 1ps;

	import cipher_pkg::*;
	import ctrl_pkg::*;

	localparam int ROUNDS = 8;

	logic   clk;
	logic   reset;
	cmd_t   cmd;
	logic   stream_end;
	block_t s_data;
	logic   s_valid;
	logic   s_ready;
	block_t m_data;
	logic   m_valid;
	logic   m_ready;
	logic   processing_done;

	block_t exp_q[$];
	block_t rx_q[$];
	block_t exp_blk;
	int     errors;
	int     done_count;
	logic   hold;

	cipher_top #(
		.ROUNDS(ROUNDS),
		.DEPTH(8)
	) dut_i (
		.clk(clk),
		.reset(reset),
		.cmd(cmd),
		.stream_end(stream_end),
		.s_data(s_data),
		.s_valid(s_valid),
		.s_ready(s_ready),
		.m_data(m_data),
		.m_valid(m_valid),
		.m_ready(m_ready),
		.processing_done(processing_done)
	);

	always #50 clk = ~clk;

	function automatic block_t rand_block();
		return {$urandom(), $urandom(), $urandom(), $urandom()};
	endfunction

	// Inverse walks the round keys backwards
	function automatic block_t cipher(key_t k, block_t b, logic inv);
		half_t  l;
		half_t  r;
		half_t  t;
		round_t idx;
		l = b[127:64];
		r = b[63:0];
		for (int i = 0; i < ROUNDS; i++) begin
			idx = inv ? round_t'(ROUNDS - 1 - i) : round_t'(i);
			t = l ^ round_f(r, round_key(k, idx));
			l = r;
			r = t;
		end
		return {r, l};
	endfunction

	task automatic model(input cmd_t c, input key_t k, input block_t iv, input block_t din[$],
			output block_t res[$]);
		block_t o;
		res = {};
		foreach (din[i]) begin
			case (c.mode)
				mode_cbc: begin
					if (c.decrypt) begin
						o = cipher(k, din[i], 1'b1) ^ iv;
						iv = din[i];
					end else begin
						o = cipher(k, din[i] ^ iv, 1'b0);
						iv = o;
					end
				end
				mode_ctr: begin
					o = cipher(k, iv, 1'b0) ^ din[i];
					iv = iv + 1'b1;
				end
				default: o = cipher(k, din[i], c.decrypt);
			endcase
			res.push_back(o);
		end
	endtask

	task automatic finish_run();
		$display("errors: %0d check failures, %0d assertion failures", errors,
			dut_i.assert_i.fail_count);
		if (errors == 0 && dut_i.assert_i.fail_count == 0) begin
			$display("Simulation completed successfully");
		end else begin
			$display("Simulation failed");
		end
		$finish;
	endtask

	task automatic abort(input string msg);
		errors++;
		$display("%s", msg);
		finish_run();
	endtask

	task automatic send_beat(input block_t d);
		int   t;
		logic xfer;
		if ($urandom_range(3) == 0) begin
			@(posedge clk);
			#5;
		end
		s_data = d;
		s_valid = 1'b1;
		xfer = 1'b0;
		t = 0;
		while (!xfer) begin
			@(negedge clk);
			xfer = s_ready;
			@(posedge clk);
			#5;
			t++;
			if (t > 1000) abort("timeout waiting for the input stream to accept a beat");
		end
		s_valid = 1'b0;
	endtask

	task automatic run_stream(input cmd_t c, input key_t k, input block_t iv,
			input block_t din[$], input block_t exp[$]);
		int done_base;
		int t;
		done_base = done_count;
		rx_q.delete();
		foreach (exp[i]) exp_q.push_back(exp[i]);
		cmd = c;
		send_beat(k);
		if (c.mode != mode_ecb) send_beat(iv);
		foreach (din[i]) send_beat(din[i]);
		stream_end = 1'b1;
		t = 0;
		while (done_count == done_base) begin
			@(posedge clk);
			#5;
			t++;
			if (t > 5000) abort("timeout waiting for processing_done");
		end
		t = 0;
		while (exp_q.size() != 0) begin
			@(posedge clk);
			#5;
			t++;
			if (t > 5000) abort("timeout waiting for the output stream to drain");
		end
		stream_end = 1'b0;
		assert (done_count == done_base + 1) else begin
			$display("processing_done pulsed %0d times in one stream", done_count - done_base);
			errors++;
		end
	endtask

	// Random sink stalls plus a forced stall while hold is set
	always @(posedge clk) begin
		#5;
		m_ready = !hold && ($urandom_range(3) != 0);
	end

	always @(negedge clk) begin
		if (!reset) begin
			if (processing_done) begin
				done_count++;
				assert (exp_q.size() == int'(dut_i.out_fifo_i.count)) else begin
					$display("processing_done came before all outputs were produced");
					errors++;
				end
			end
			if (m_valid && m_ready) begin
				if (exp_q.size() == 0) begin
					$display("output beat with no expected value");
					errors++;
				end else begin
					exp_blk = exp_q.pop_front();
					assert (m_data == exp_blk) else begin
						$display("mismatch m_data expected %h actual %h", exp_blk, m_data);
						errors++;
					end
					rx_q.push_back(m_data);
				end
			end
		end
	end

	initial begin
		block_t pt[$];
		block_t ct[$];
		block_t exp[$];
		key_t   k;
		block_t iv;
		cmd_t   c;
		void'($urandom(37));
		clk = 1'b0;
		reset = 1'b1;
		cmd = '0;
		stream_end = 1'b0;
		s_data = '0;
		s_valid = 1'b0;
		m_ready = 1'b0;
		hold = 1'b0;
		errors = 0;
		done_count = 0;
		repeat (5) @(posedge clk);
		#5;
		reset = 1'b0;

		// ECB with a repeated plaintext block
		k = rand_block();
		iv = rand_block();
		for (int i = 0; i < 6; i++) pt.push_back(rand_block());
		pt[4] = pt[1];
		c = '{mode: mode_ecb, decrypt: 1'b0};
		model(c, k, iv, pt, exp);
		run_stream(c, k, iv, pt, exp);
		assert (rx_q.size() == 6 && rx_q[1] == rx_q[4]) else begin
			$display("equal ECB plaintext blocks gave different ciphertext");
			errors++;
		end

		// CBC round trip then CTR round trip
		for (int m = 0; m < 2; m++) begin
			k = rand_block();
			iv = rand_block();
			c = '{mode: (m == 0) ? mode_cbc : mode_ctr, decrypt: 1'b0};
			model(c, k, iv, pt, exp);
			run_stream(c, k, iv, pt, exp);
			ct = rx_q;
			c.decrypt = (m == 0);
			run_stream(c, k, iv, ct, pt);
		end

		// Long ECB decrypt stream with a 30 cycle sink stall
		k = rand_block();
		pt.delete();
		for (int i = 0; i < 16; i++) pt.push_back(rand_block());
		c = '{mode: mode_ecb, decrypt: 1'b1};
		model(c, k, iv, pt, exp);
		fork
			run_stream(c, k, iv, pt, exp);
			begin
				repeat (20) @(posedge clk);
				hold = 1'b1;
				repeat (30) @(posedge clk);
				hold = 1'b0;
			end
		join
		finish_run();
	end
endmodule

// File: list.f
verilog/cipher_pkg.sv
verilog/ctrl_pkg.sv
verilog/block_fifo.sv
verilog/feistel_core.sv
verilog/mode_chain.sv
verilog/cipher_controller.sv
verilog/cipher_top.sv
dv/cipher_assert.sv
dv/cipher_tb.sv

// File: run.sh
#!/usr/bin/env bash
# Build and run the cipher testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps -Wno-fatal \
	-f list.f --top-module cipher_tb -Mdir obj_dir
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

out=$(./obj_dir/Vcipher_tb +verilator+error+limit+1000)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if echo "$out" | grep -qxF "Simulation completed successfully"; then
	exit 0
fi
exit 1
